// File: logic/tcm_pkg.sv
`default_nettype none

package tcm_pkg;

    // ====================
    // Data path widths
    // ====================
    localparam int XLEN = 32;                          // Core data width
    localparam int MASK_W = XLEN / 8;                  // One enable per byte lane

    typedef logic [XLEN-1:0]   word_t;                 // One data word
    typedef logic [XLEN-1:0]   addr_t;                 // Byte address
    typedef logic [MASK_W-1:0] mask_t;                 // Byte lane write enables

    // ====================
    // Memory geometry
    // ====================
    localparam int ITCM_WORDS = 256;                   // 1 KiB instruction memory
    localparam int DTCM_WORDS = 256;                   // 1 KiB data memory
    localparam int ITCM_AW = $clog2(ITCM_WORDS);       // ITCM word index width
    localparam int DTCM_AW = $clog2(DTCM_WORDS);       // DTCM word index width
    localparam int WORD_LSB = 2;                       // Byte offset bits below the index

    // Region select, higher bits alias
    localparam int REGION_BIT = 10;                    // 0 ITCM, 1 DTCM

    // ====================
    // Power-up contents
    // ====================
    localparam word_t ITCM_FILL = 32'h0000_0013;       // addi x0, x0, 0
    localparam word_t DTCM_FILL = 32'h0000_0000;       // Cleared data

endpackage

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ====================
    // Access size
    // ====================
    // Low two bits of the load/store funct3
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,                             // lb, lbu, sb
        SIZE_HALF = 2'b01,                             // lh, lhu, sh
        SIZE_WORD = 2'b10                              // lw, sw
    } access_size_e;

    // ====================
    // Response slot
    // ====================
    // What the unit reports in the cycle after it takes a request
    typedef enum logic [1:0] {
        SLOT_IDLE  = 2'b00,                            // Nothing, or a store
        SLOT_LOAD  = 2'b01,                            // Load data returns
        SLOT_FAULT = 2'b10                             // Misaligned access
    } slot_state_e;

endpackage

`default_nettype wire

// File: logic/sim_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sim_ram import tcm_pkg::*; #(
    parameter int    DEPTH     = 256,                  // Word count
    parameter word_t INIT_WORD = '0                    // Fill value at time zero
) (
    input  wire                     clk,
    input  word_t                   din,               // Lane-replicated write data
    input  wire [$clog2(DEPTH)-1:0] addr,              // Word index
    input  wire                     we,                // Write cycle
    input  mask_t                   wem,               // Byte lanes to write
    output word_t                   dout               // Word at the held read address
);

    word_t                   mem [DEPTH];              // Storage array
    logic [$clog2(DEPTH)-1:0] addr_r;                  // Held read address
    mask_t                   wen;                      // Per-lane write strobes

    assign wen = {MASK_W{we}} & wem;

    // Read address only moves on non-write edges
    always_ff @(posedge clk) begin
        if (!we) begin
            addr_r <= addr;
        end
    end

    // Byte lane writes
    always @(posedge clk) begin
        for (int i = 0; i < MASK_W; i++) begin
            if (wen[i]) begin
                mem[addr][8*i +: 8] <= din[8*i +: 8];  // One lane per mask bit
            end
        end
    end

    assign dout = mem[addr_r];                         // Holds through write cycles

    // Constant power-up contents
    initial begin
        for (int j = 0; j < DEPTH; j++) begin
            mem[j] = INIT_WORD;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_unit import tcm_pkg::*, lsu_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    // Core data port
    input  wire          data_req,                     // Request strobe
    input  wire          data_we,                      // Store when high
    input  addr_t        data_addr,                    // Byte address
    input  access_size_e data_size,                    // Byte, half or word
    input  wire          data_unsigned,                // Zero-extend loads
    input  word_t        data_wdata,                   // Store data, low aligned
    output logic         data_stall,                   // Hold request
    output logic         load_valid,                   // Load result pulse
    output word_t        load_data,                    // Extended load result
    output logic         misaligned,                   // Fault pulse
    // Router side
    output logic         mem_req,                      // Aligned access
    output logic         mem_we,                       // Aligned store
    output addr_t        mem_addr,                     // Byte address
    output mask_t        mem_mask,                     // Byte lanes
    output word_t        mem_wdata,                    // Lane-replicated data
    input  wire          mem_stall,                    // ITCM busy with fetch
    input  word_t        mem_rdata                     // Raw word of the load
);

    logic        aligned;                              // Address fits the size
    logic        taken;                                // Request accepted this edge
    slot_state_e slot_d;                               // Next slot report
    slot_state_e slot_q;                               // Current slot report
    logic [1:0]  off_q;                                // Byte offset of the load
    access_size_e size_q;                              // Size of the load
    logic        unsigned_q;                           // Zero-extend flag
    word_t       shifted;                              // Loaded bytes moved to lane 0
    logic        ext_bit;                              // Fill bit for the upper bits

    // ====================
    // Request side
    // ====================
    always_comb begin
        unique case (data_size)
            SIZE_BYTE: aligned = 1'b1;                 // Any offset
            SIZE_HALF: aligned = ~data_addr[0];        // Even bytes
            default:   aligned = (data_addr[1:0] == 2'b00);
        endcase
    end

    assign mem_req  = data_req & aligned;              // Misaligned never leaves
    assign mem_we   = mem_req & data_we;
    assign mem_addr = data_addr;

    // Mask and replicated store data
    always_comb begin
        unique case (data_size)
            SIZE_BYTE: begin
                mem_mask  = mask_t'(4'b0001) << data_addr[1:0];
                mem_wdata = {4{data_wdata[7:0]}};
            end
            SIZE_HALF: begin
                mem_mask  = mask_t'(4'b0011) << data_addr[1:0];
                mem_wdata = {2{data_wdata[15:0]}};
            end
            default: begin
                mem_mask  = '1;                        // Full word
                mem_wdata = data_wdata;
            end
        endcase
    end

    assign data_stall = mem_stall;                     // Only raised for aligned ITCM use
    assign taken      = data_req & ~mem_stall;

    // ====================
    // Response slot
    // ====================
    always_comb begin
        slot_d = SLOT_IDLE;
        if (taken) begin
            if (!aligned) begin
                slot_d = SLOT_FAULT;                   // Store or load alike
            end else if (!data_we) begin
                slot_d = SLOT_LOAD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q <= SLOT_IDLE;
        end else begin
            slot_q <= slot_d;
        end
    end

    // Load details, captured with the slot
    always_ff @(posedge clk) begin
        if (taken) begin
            off_q      <= data_addr[1:0];
            size_q     <= data_size;
            unsigned_q <= data_unsigned;
        end
    end

    assign load_valid = (slot_q == SLOT_LOAD);
    assign misaligned = (slot_q == SLOT_FAULT);

    // ====================
    // Load extraction
    // ====================
    assign shifted = mem_rdata >> {off_q, 3'b000};     // Offset in bits

    always_comb begin
        unique case (size_q)
            SIZE_BYTE: begin
                ext_bit   = ~unsigned_q & shifted[7];
                load_data = {{(XLEN-8){ext_bit}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                ext_bit   = ~unsigned_q & shifted[15];
                load_data = {{(XLEN-16){ext_bit}}, shifted[15:0]};
            end
            default: begin
                ext_bit   = 1'b0;                      // Nothing to extend
                load_data = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/tcm_router.sv
`timescale 1ns/100ps
`default_nettype none

module tcm_router import tcm_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    // Fetch port
    input  wire               fetch_req,               // Never stalled
    input  addr_t             fetch_addr,
    output logic              instr_valid,             // One cycle after fetch_req
    output word_t             instr,
    // From the load-store unit
    input  wire               mem_req,
    input  wire               mem_we,
    input  addr_t             mem_addr,
    input  mask_t             mem_mask,
    input  word_t             mem_wdata,
    output logic              mem_stall,
    output word_t             mem_rdata,
    // ITCM RAM
    output logic [ITCM_AW-1:0] itcm_addr,
    output word_t             itcm_din,
    output logic              itcm_we,
    output mask_t             itcm_wem,
    input  word_t             itcm_dout,
    // DTCM RAM
    output logic [DTCM_AW-1:0] dtcm_addr,
    output word_t             dtcm_din,
    output logic              dtcm_we,
    output mask_t             dtcm_wem,
    input  word_t             dtcm_dout
);

    logic data_dtcm;                                   // Access targets the DTCM
    logic data_itcm;                                   // Access wants the ITCM
    logic fetch_q;                                     // Fetch issued last cycle
    logic load_dtcm_q;                                 // Last load read the DTCM

    // ====================
    // Region decode
    // ====================
    assign data_dtcm = mem_addr[REGION_BIT];           // Bits above alias
    assign data_itcm = mem_req & ~data_dtcm;
    assign mem_stall = data_itcm & fetch_req;          // Fetch wins the ITCM

    // ITCM, fetch first
    assign itcm_addr = fetch_req ? fetch_addr[WORD_LSB +: ITCM_AW]
                                 : mem_addr[WORD_LSB +: ITCM_AW];
    assign itcm_we   = data_itcm & mem_we & ~fetch_req;
    assign itcm_wem  = mem_mask;
    assign itcm_din  = mem_wdata;

    // DTCM, data port only
    assign dtcm_addr = mem_addr[WORD_LSB +: DTCM_AW];
    assign dtcm_we   = mem_req & data_dtcm & mem_we;
    assign dtcm_wem  = mem_mask;
    assign dtcm_din  = mem_wdata;

    // ====================
    // Return steering
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= fetch_req;
        end
    end

    // Region of a load that reached its RAM
    always_ff @(posedge clk) begin
        if (mem_req && !mem_we && !mem_stall) begin
            load_dtcm_q <= data_dtcm;
        end
    end

    assign instr_valid = fetch_q;
    assign instr       = itcm_dout;                    // Read address held from the fetch
    assign mem_rdata   = load_dtcm_q ? dtcm_dout : itcm_dout;

endmodule

`default_nettype wire

// File: logic/tcm_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tcm_subsystem import tcm_pkg::*, lsu_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    // Fetch side
    input  wire          fetch_req,
    input  addr_t        fetch_addr,
    output logic         instr_valid,
    output word_t        instr,
    // Data side
    input  wire          data_req,
    input  wire          data_we,
    input  addr_t        data_addr,
    input  access_size_e data_size,
    input  wire          data_unsigned,
    input  word_t        data_wdata,
    output logic         data_stall,
    output logic         load_valid,
    output word_t        load_data,
    output logic         misaligned
);

    // Unit to router
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    mask_t mem_mask;
    word_t mem_wdata;
    logic  mem_stall;
    word_t mem_rdata;

    // Router to RAMs
    logic [ITCM_AW-1:0] itcm_addr;
    word_t              itcm_din;
    logic               itcm_we;
    mask_t              itcm_wem;
    word_t              itcm_dout;
    logic [DTCM_AW-1:0] dtcm_addr;
    word_t              dtcm_din;
    logic               dtcm_we;
    mask_t              dtcm_wem;
    word_t              dtcm_dout;

    lsu_unit lsu_unit_inst (
        .clk, .rst,
        .data_req, .data_we, .data_addr, .data_size, .data_unsigned, .data_wdata,
        .data_stall, .load_valid, .load_data, .misaligned,
        .mem_req, .mem_we, .mem_addr, .mem_mask, .mem_wdata, .mem_stall, .mem_rdata
    );

    tcm_router tcm_router_inst (
        .clk, .rst,
        .fetch_req, .fetch_addr, .instr_valid, .instr,
        .mem_req, .mem_we, .mem_addr, .mem_mask, .mem_wdata, .mem_stall, .mem_rdata,
        .itcm_addr, .itcm_din, .itcm_we, .itcm_wem, .itcm_dout,
        .dtcm_addr, .dtcm_din, .dtcm_we, .dtcm_wem, .dtcm_dout
    );

    // Instruction memory, starts as NOPs
    sim_ram #(.DEPTH(ITCM_WORDS), .INIT_WORD(ITCM_FILL)) itcm_ram (
        .clk,
        .din(itcm_din), .addr(itcm_addr), .we(itcm_we), .wem(itcm_wem), .dout(itcm_dout)
    );

    // Data memory, starts cleared
    sim_ram #(.DEPTH(DTCM_WORDS), .INIT_WORD(DTCM_FILL)) dtcm_ram (
        .clk,
        .din(dtcm_din), .addr(dtcm_addr), .we(dtcm_we), .wem(dtcm_wem), .dout(dtcm_dout)
    );

endmodule

`default_nettype wire

// File: tb/tcm_properties.sv
`timescale 1ns/100ps
`default_nettype none

module tcm_properties (
    input wire clk,
    input wire rst,
    input wire fetch_req,
    input wire instr_valid,
    input wire load_valid,
    input wire misaligned,
    input wire data_stall
);

    // Every fetch answered on the next cycle
    fetch_answered: assert property (@(posedge clk) disable iff (rst) fetch_req |=> instr_valid)
        else $error("instr_valid missing one cycle after fetch_req");

    // No answer without a fetch
    fetch_only: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> $past(fetch_req))
        else $error("instr_valid without a fetch_req one cycle earlier");

    // One response kind per slot
    one_response: assert property (@(posedge clk) disable iff (rst) !(load_valid && misaligned))
        else $error("load_valid and misaligned high together");

    stall_cause: assert property (@(posedge clk) disable iff (rst) data_stall |-> fetch_req)
        else $error("data_stall high without fetch_req");

endmodule

bind tcm_subsystem tcm_properties tcm_properties_inst (
    .clk, .rst, .fetch_req, .instr_valid, .load_valid, .misaligned, .data_stall
);

`default_nettype wire

// File: tb/tcm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tcm_tb import tcm_pkg::*, lsu_pkg::*; ();

    logic         clk = 1'b0;
    logic         rst;
    logic         fetch_req;
    addr_t        fetch_addr;
    logic         instr_valid;
    word_t        instr;
    logic         data_req;
    logic         data_we;
    addr_t        data_addr;
    access_size_e data_size;
    logic         data_unsigned;
    word_t        data_wdata;
    logic         data_stall;
    logic         load_valid;
    word_t        load_data;
    logic         misaligned;

    logic [7:0] ref_mem [2048];                        // Byte model, DTCM in the upper half
    word_t      lfsr;
    int         cycle = 0;                             // Rising edges since time zero
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         test_errors;
    string      cur_test;
    word_t      fetch_exp_q[$];                        // Expected words, oldest first
    word_t      load_exp_q[$];
    int         fetch_due_q[$];                        // Cycle each pulse is due
    int         load_due_q[$];
    int         fault_due_q[$];

    always #50 clk = ~clk;                             // 100 ns period

    always @(posedge clk) cycle <= cycle + 1;

    tcm_subsystem tcm_subsystem_inst (.*);

    // ====================
    // Random numbers and reference model
    // ====================
    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                    // One step per bit
            r    = {r[XLEN-2:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int size_bytes(input access_size_e s);
        return (s == SIZE_BYTE) ? 1 : ((s == SIZE_HALF) ? 2 : 4);
    endfunction

    function automatic logic is_aligned(input addr_t a, input access_size_e s);
        return (a[1:0] & 2'(size_bytes(s) - 1)) == 2'b00;
    endfunction

    function automatic logic [10:0] ref_index(input addr_t a);
        return {a[REGION_BIT], a[9:0]};                // Bits above the region alias
    endfunction

    function automatic access_size_e pick_size();
        word_t r;
        r = rand_bits(2);
        return (r[1:0] == 2'b11) ? SIZE_WORD : access_size_e'(r[1:0]);
    endfunction

    // Aligned address among 16 words so that loads revisit stores
    function automatic addr_t rand_addr(input logic region, input access_size_e s);
        addr_t a;
        a             = rand_bits(XLEN);
        a[REGION_BIT] = region;
        a[9:6]        = 4'd0;
        a[1:0]        = a[1:0] & ~2'(size_bytes(s) - 1);
        return a;
    endfunction

    // Gather the bytes, then sign- or zero-extend
    function automatic word_t load_ref(input addr_t a, input access_size_e s, input logic uns);
        word_t v;
        int    n;
        n = size_bytes(s);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = ref_mem[ref_index(a) + 11'(k)];
        end
        if (!uns && v[8*n-1]) begin
            for (int k = n; k < 4; k++) begin
                v[8*k +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    // Every response pulse against what was queued when its request was taken
    initial begin
        logic due;
        forever begin
            @(negedge clk);
            if (!rst) begin
                due = (fetch_due_q.size() > 0) && (fetch_due_q[0] == cycle);
                check_flag("instr_valid", due, instr_valid);
                if (due && instr_valid) check_word("instr", fetch_exp_q[0], instr);
                if (due) begin
                    void'(fetch_due_q.pop_front());
                    void'(fetch_exp_q.pop_front());
                end
                due = (load_due_q.size() > 0) && (load_due_q[0] == cycle);
                check_flag("load_valid", due, load_valid);
                if (due && load_valid) check_word("load_data", load_exp_q[0], load_data);
                if (due) begin
                    void'(load_due_q.pop_front());
                    void'(load_exp_q.pop_front());
                end
                due = (fault_due_q.size() > 0) && (fault_due_q[0] == cycle);
                check_flag("misaligned", due, misaligned);
                if (due) void'(fault_due_q.pop_front());
            end
        end
    end

    // ====================
    // Drivers, called just after a rising edge
    // ====================
    task automatic fetch_burst(input int first_word, input int n);
        for (int i = 0; i < n; i++) begin
            fetch_req  <= 1'b1;
            fetch_addr <= addr_t'(4 * (first_word + i));
            @(negedge clk);
            fetch_exp_q.push_back(load_ref(addr_t'(4 * (first_word + i)), SIZE_WORD, 1'b0));
            fetch_due_q.push_back(cycle + 1);
            @(posedge clk);
        end
        fetch_req <= 1'b0;
    endtask

    task automatic data_access(input logic we, input addr_t a, input access_size_e s,
                               input logic uns, input word_t wd);
        int waited;
        data_req      <= 1'b1;
        data_we       <= we;
        data_addr     <= a;
        data_size     <= s;
        data_unsigned <= uns;
        data_wdata    <= wd;
        for (waited = 0; waited < 32; waited++) begin
            @(negedge clk);
            // Held only by an aligned ITCM access during a fetch
            check_flag("data_stall", fetch_req & is_aligned(a, s) & ~a[REGION_BIT], data_stall);
            if (!data_stall) break;
            @(posedge clk);
        end
        if (waited == 32) begin
            errors++;
            $display("%s: data_stall stayed high for 32 cycles", cur_test);
        end else if (!is_aligned(a, s)) begin
            fault_due_q.push_back(cycle + 1);
        end else if (we) begin
            for (int k = 0; k < size_bytes(s); k++) begin
                ref_mem[ref_index(a) + 11'(k)] = wd[8*k +: 8];
            end
        end else begin
            load_exp_q.push_back(load_ref(a, s, uns));
            load_due_q.push_back(cycle + 1);
        end
        @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic finish_test;
        int left;
        data_req <= 1'b0;
        for (left = 8; left > 0; left--) begin
            @(negedge clk);
            if (fetch_due_q.size() + load_due_q.size() + fault_due_q.size() == 0) break;
        end
        if (left == 0) begin
            errors++;
            $display("%s: responses still missing after 8 cycles", cur_test);
        end
        $display("%s done, %0d errors", cur_test, errors - test_errors);
        @(posedge clk);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        access_size_e sz;
        rst           = 1'b1;
        fetch_req     = 1'b0;
        fetch_addr    = '0;
        data_req      = 1'b0;
        data_we       = 1'b0;
        data_addr     = '0;
        data_size     = SIZE_WORD;
        data_unsigned = 1'b0;
        data_wdata    = '0;
        lfsr          = 32'd1;
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = (i < 1024) ? ITCM_FILL[8*(i%4) +: 8] : DTCM_FILL[8*(i%4) +: 8];
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        start_test("fill");
        fetch_burst(0, 4);
        fetch_burst(252, 4);
        for (int i = 0; i < 4; i++) begin
            data_access(1'b0, addr_t'(32'h400 + 244 * i), SIZE_WORD, 1'b0, '0);
        end
        finish_test;

        start_test("dtcm");                            // 24 stores, then 40 loads
        for (int i = 0; i < 64; i++) begin
            sz = pick_size();
            data_access(i < 24, rand_addr(1'b1, sz), sz, rand_bits(1) != 0, rand_bits(XLEN));
        end
        finish_test;

        start_test("itcm");
        for (int i = 0; i < 8; i++) begin
            sz = (i < 4) ? SIZE_WORD : SIZE_BYTE;
            data_access(1'b1, addr_t'(32 + 4 * i + ((i < 4) ? 0 : i % 4)), sz, 1'b0,
                        rand_bits(XLEN));
        end
        data_req <= 1'b0;
        fetch_burst(8, 8);
        finish_test;

        start_test("priority");
        fork
            fetch_burst(40, 5);
            begin
                data_access(1'b1, addr_t'(32'h0F0), SIZE_WORD, 1'b0, rand_bits(XLEN));
                data_req <= 1'b0;
            end
        join
        fork
            fetch_burst(58, 3);
            begin
                data_access(1'b0, addr_t'(32'h403), SIZE_BYTE, 1'b1, '0);
                data_access(1'b0, addr_t'(32'h0F2), SIZE_HALF, 1'b0, '0);
                data_req <= 1'b0;
            end
        join
        finish_test;

        start_test("misalign");
        fork
            fetch_burst(60, 2);
            begin
                data_access(1'b1, addr_t'(32'h0F1), SIZE_HALF, 1'b0, 32'hDEAD_BEEF);
                data_access(1'b1, addr_t'(32'h406), SIZE_WORD, 1'b0, 32'hDEAD_BEEF);
                data_access(1'b0, addr_t'(32'h403), SIZE_HALF, 1'b1, '0);
                data_access(1'b0, addr_t'(32'h40A), SIZE_WORD, 1'b0, '0);
                data_access(1'b0, addr_t'(32'h404), SIZE_WORD, 1'b0, '0);
                data_req <= 1'b0;
            end
        join
        fetch_burst(60, 1);                            // ITCM word still intact
        finish_test;

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/tcm_pkg.sv
logic/lsu_pkg.sv
logic/sim_ram.sv
logic/lsu_unit.sv
logic/tcm_router.sv
logic/tcm_subsystem.sv
tb/tcm_properties.sv
tb/tcm_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tcm_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
